// File: src/dmiss_pkg.sv
package dmiss_pkg;

  // cache line address width, byte offset bits stripped.
  localparam int LINE_ADDR_W = 36;

  typedef logic [LINE_ADDR_W-1:0] line_addr_t;

  // replay sequencing of the miss buffer.
  // RS_IDLE holds nothing new since the last unlock.
  // RS_COLLECT gathers misses until every entry has been read.
  // RS_REPLAY locks the buffer and requests replay.
  typedef enum logic [1:0] {
    RS_IDLE    = 2'd0,
    RS_COLLECT = 2'd1,
    RS_REPLAY  = 2'd2
  } replay_state_e;

endpackage

// File: src/miss_entry.sv
`timescale 1ns/1ps

module miss_entry #(
  parameter int NUM_PORTS = 4
) (
  input  logic                                  clk,
  input  logic                                  rst,
  input  logic                                  wr_en_i,
  input  dmiss_pkg::line_addr_t                 wr_addr_i,
  input  logic [NUM_PORTS-1:0]                  req_valid_i,
  input  dmiss_pkg::line_addr_t [NUM_PORTS-1:0] req_addr_i,
  input  logic                                  rd_clr_i,
  input  logic                                  release_i,
  output logic                                  busy_o,
  output logic                                  pending_o,
  output dmiss_pkg::line_addr_t                 addr_o,
  output logic [NUM_PORTS-1:0]                  match_o
);

  logic                  busy_q;
  logic                  pending_q;
  dmiss_pkg::line_addr_t addr_q;

  // release wins over everything, then allocation, then readout.
  always_ff @(posedge clk) begin
    if (rst) begin
      busy_q    <= 1'b0;
      pending_q <= 1'b0;
    end else if (release_i) begin
      busy_q    <= 1'b0;
      pending_q <= 1'b0;
    end else if (wr_en_i) begin
      busy_q    <= 1'b1;
      pending_q <= 1'b1;
    end else if (rd_clr_i) begin
      pending_q <= 1'b0;
    end
  end

  // line captured on allocation.
  always_ff @(posedge clk) begin
    if (wr_en_i) begin
      addr_q <= wr_addr_i;
    end
  end

  always_comb begin
    for (int p = 0; p < NUM_PORTS; p++) begin
      match_o[p] = busy_q && req_valid_i[p] && (req_addr_i[p] == addr_q);
    end
  end

  assign busy_o    = busy_q;
  assign pending_o = pending_q;
  assign addr_o    = addr_q;

  // a held line stays put until release.
  a_line_stable: assert property (@(posedge clk) disable iff (rst)
    busy_q && !release_i |=> addr_q == $past(addr_q));

endmodule

// File: src/miss_alloc.sv
`timescale 1ns/1ps

module miss_alloc #(
  parameter int NUM_PORTS   = 4,
  parameter int NUM_ENTRIES = 8
) (
  input  logic [NUM_PORTS-1:0]                    req_valid_i,
  input  dmiss_pkg::line_addr_t [NUM_PORTS-1:0]   req_addr_i,
  input  logic [NUM_ENTRIES-1:0]                  entry_busy_i,
  input  logic [NUM_ENTRIES-1:0][NUM_PORTS-1:0]   entry_match_i,
  input  logic                                    accepting_i,
  output logic [NUM_PORTS-1:0]                    accept_o,
  output logic [NUM_ENTRIES-1:0]                  wr_en_o,
  output dmiss_pkg::line_addr_t [NUM_ENTRIES-1:0] wr_addr_o,
  output logic                                    any_wr_o
);

  localparam int MAX_N = (NUM_PORTS > NUM_ENTRIES) ? NUM_PORTS : NUM_ENTRIES;
  localparam int CNT_W = $clog2(MAX_N + 1);

  logic [NUM_PORTS-1:0]              hit;
  logic [NUM_PORTS-1:0]              dup;
  logic [NUM_PORTS-1:0]              cand;
  logic [NUM_PORTS-1:0][CNT_W-1:0]   rank;
  logic [CNT_W-1:0]                  cand_run;
  logic [NUM_ENTRIES-1:0][CNT_W-1:0] free_rank;
  logic [CNT_W-1:0]                  free_cnt;

  // hit against a held line.
  always_comb begin
    hit = '0;
    for (int p = 0; p < NUM_PORTS; p++) begin
      for (int e = 0; e < NUM_ENTRIES; e++) begin
        if (entry_match_i[e][p]) begin
          hit[p] = 1'b1;
        end
      end
    end
  end

  // same line already carried by a lower port.
  always_comb begin
    dup = '0;
    for (int p = 0; p < NUM_PORTS; p++) begin
      for (int q = 0; q < NUM_PORTS; q++) begin
        if (q < p && req_valid_i[q] && (req_addr_i[q] == req_addr_i[p])) begin
          dup[p] = 1'b1;
        end
      end
    end
  end

  assign cand = req_valid_i & ~hit & ~dup & {NUM_PORTS{accepting_i}};

  // rank of each candidate in port order.
  always_comb begin
    cand_run = '0;
    for (int p = 0; p < NUM_PORTS; p++) begin
      rank[p] = cand_run;
      if (cand[p]) begin
        cand_run = cand_run + CNT_W'(1);
      end
    end
  end

  // position of each free entry in index order.
  always_comb begin
    free_cnt = '0;
    for (int e = 0; e < NUM_ENTRIES; e++) begin
      free_rank[e] = free_cnt;
      if (!entry_busy_i[e]) begin
        free_cnt = free_cnt + CNT_W'(1);
      end
    end
  end

  always_comb begin
    for (int p = 0; p < NUM_PORTS; p++) begin
      accept_o[p] = cand[p] && (rank[p] < free_cnt);
    end
  end

  // candidate of rank r lands in the r-th free entry.
  always_comb begin
    wr_en_o   = '0;
    wr_addr_o = '0;
    for (int e = 0; e < NUM_ENTRIES; e++) begin
      for (int p = 0; p < NUM_PORTS; p++) begin
        if (!entry_busy_i[e] && accept_o[p] && (rank[p] == free_rank[e])) begin
          wr_en_o[e]   = 1'b1;
          wr_addr_o[e] = req_addr_i[p];
        end
      end
    end
  end

  assign any_wr_o = |wr_en_o;

  // every accepted port lands in exactly one entry.
  always_comb begin
    a_one_wr_per_accept: assert ($countones(wr_en_o) == $countones(accept_o))
      else $error("writes %b do not pair with accepts %b", wr_en_o, accept_o);
  end

endmodule

// File: src/miss_replay.sv
`timescale 1ns/1ps

module miss_replay #(
  parameter int NUM_ENTRIES = 8
) (
  input  logic                                    clk,
  input  logic                                    rst,
  input  logic [NUM_ENTRIES-1:0]                  entry_busy_i,
  input  logic [NUM_ENTRIES-1:0]                  entry_pending_i,
  input  dmiss_pkg::line_addr_t [NUM_ENTRIES-1:0] entry_addr_i,
  input  logic                                    rd_en_i,
  input  logic [$clog2(NUM_ENTRIES)-1:0]          rd_idx_i,
  input  logic                                    any_valid_i,
  input  logic                                    any_wr_i,
  input  logic                                    unlock_i,
  output logic [NUM_ENTRIES-1:0]                  rd_clr_o,
  output dmiss_pkg::line_addr_t                   rd_addr_o,
  output logic                                    replay_o,
  output logic                                    accepting_o,
  output logic                                    release_o
);

  localparam int IDX_W = $clog2(NUM_ENTRIES);

  dmiss_pkg::replay_state_e state_q;
  dmiss_pkg::replay_state_e state_d;
  logic                     any_pending;

  assign any_pending = |entry_pending_i;

  always_comb begin
    state_d = state_q;
    case (state_q)
      dmiss_pkg::RS_IDLE: begin
        if (any_wr_i) begin
          state_d = dmiss_pkg::RS_COLLECT;
        end
      end
      dmiss_pkg::RS_COLLECT: begin
        // quiet cycle with everything read out.
        if (!any_pending && !any_valid_i && !any_wr_i) begin
          state_d = dmiss_pkg::RS_REPLAY;
        end
      end
      dmiss_pkg::RS_REPLAY: begin
        if (unlock_i) begin
          state_d = dmiss_pkg::RS_IDLE;
        end
      end
      default: state_d = dmiss_pkg::RS_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= dmiss_pkg::RS_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  assign replay_o    = (state_q == dmiss_pkg::RS_REPLAY);
  assign accepting_o = (state_q != dmiss_pkg::RS_REPLAY);
  assign release_o   = replay_o && unlock_i;

  // index decode and readout mux.
  always_comb begin
    rd_clr_o  = '0;
    rd_addr_o = '0;
    for (int e = 0; e < NUM_ENTRIES; e++) begin
      if (rd_idx_i == IDX_W'(e)) begin
        rd_clr_o[e] = rd_en_i;
        if (entry_busy_i[e]) begin
          rd_addr_o = entry_addr_i[e];
        end
      end
    end
  end

  // unlock empties every entry by the next cycle.
  a_release_empties: assert property (@(posedge clk) disable iff (rst)
    release_o |=> !(|entry_busy_i));

endmodule

// File: src/dmiss_cam.sv
`timescale 1ns/1ps

module dmiss_cam #(
  parameter int NUM_PORTS   = 4,
  parameter int NUM_ENTRIES = 8
) (
  input  logic                                  clk,
  input  logic                                  rst,
  input  logic [NUM_PORTS-1:0]                  req_valid_i,
  input  dmiss_pkg::line_addr_t [NUM_PORTS-1:0] req_addr_i,
  output logic [NUM_PORTS-1:0]                  accept_o,
  output logic                                  has_free_o,
  input  logic                                  rd_en_i,
  input  logic [$clog2(NUM_ENTRIES)-1:0]        rd_idx_i,
  output dmiss_pkg::line_addr_t                 rd_addr_o,
  output logic                                  replay_o,
  input  logic                                  unlock_i
);

  logic [NUM_ENTRIES-1:0]                  entry_busy;
  logic [NUM_ENTRIES-1:0]                  entry_pending;
  dmiss_pkg::line_addr_t [NUM_ENTRIES-1:0] entry_addr;
  logic [NUM_ENTRIES-1:0][NUM_PORTS-1:0]   entry_match;
  logic [NUM_ENTRIES-1:0]                  wr_en;
  dmiss_pkg::line_addr_t [NUM_ENTRIES-1:0] wr_addr;
  logic [NUM_ENTRIES-1:0]                  rd_clr;
  logic                                    any_wr;
  logic                                    any_valid;
  logic                                    accepting;
  logic                                    release_all;

  assign has_free_o = ~(&entry_busy);
  assign any_valid  = |req_valid_i;

  miss_alloc #(
    .NUM_PORTS   (NUM_PORTS),
    .NUM_ENTRIES (NUM_ENTRIES)
  ) u_alloc (
    .req_valid_i   (req_valid_i),
    .req_addr_i    (req_addr_i),
    .entry_busy_i  (entry_busy),
    .entry_match_i (entry_match),
    .accepting_i   (accepting),
    .accept_o      (accept_o),
    .wr_en_o       (wr_en),
    .wr_addr_o     (wr_addr),
    .any_wr_o      (any_wr)
  );

  // one CAM entry per miss slot.
  for (genvar e = 0; e < NUM_ENTRIES; e++) begin : g_entry
    miss_entry #(
      .NUM_PORTS (NUM_PORTS)
    ) u_entry (
      .clk         (clk),
      .rst         (rst),
      .wr_en_i     (wr_en[e]),
      .wr_addr_i   (wr_addr[e]),
      .req_valid_i (req_valid_i),
      .req_addr_i  (req_addr_i),
      .rd_clr_i    (rd_clr[e]),
      .release_i   (release_all),
      .busy_o      (entry_busy[e]),
      .pending_o   (entry_pending[e]),
      .addr_o      (entry_addr[e]),
      .match_o     (entry_match[e])
    );
  end

  miss_replay #(
    .NUM_ENTRIES (NUM_ENTRIES)
  ) u_replay (
    .clk             (clk),
    .rst             (rst),
    .entry_busy_i    (entry_busy),
    .entry_pending_i (entry_pending),
    .entry_addr_i    (entry_addr),
    .rd_en_i         (rd_en_i),
    .rd_idx_i        (rd_idx_i),
    .any_valid_i     (any_valid),
    .any_wr_i        (any_wr),
    .unlock_i        (unlock_i),
    .rd_clr_o        (rd_clr),
    .rd_addr_o       (rd_addr_o),
    .replay_o        (replay_o),
    .accepting_o     (accepting),
    .release_o       (release_all)
  );

endmodule

// File: dv/dmiss_model.svh
`ifndef DMISS_MODEL_SVH
`define DMISS_MODEL_SVH

// reference copy of the miss buffer, advanced once per clock.
logic [NUM_ENTRIES-1:0]                  mdl_busy;
logic [NUM_ENTRIES-1:0]                  mdl_pending;
dmiss_pkg::line_addr_t [NUM_ENTRIES-1:0] mdl_addr;
dmiss_pkg::replay_state_e                mdl_state;

function automatic void reset_model();
  mdl_busy    = '0;
  mdl_pending = '0;
  mdl_addr    = '0;
  mdl_state   = dmiss_pkg::RS_IDLE;
endfunction

function automatic int free_entries();
  int n;
  n = 0;
  for (int e = 0; e < NUM_ENTRIES; e++) begin
    if (!mdl_busy[e]) begin
      n++;
    end
  end
  return n;
endfunction

// ports that allocate at the coming edge.
function automatic logic [NUM_PORTS-1:0] predict_accept(
  input logic [NUM_PORTS-1:0]                  valid,
  input dmiss_pkg::line_addr_t [NUM_PORTS-1:0] addrs
);
  logic [NUM_PORTS-1:0] acc;
  logic                 seen;
  int                   rank;
  acc  = '0;
  rank = 0;
  for (int p = 0; p < NUM_PORTS; p++) begin
    seen = 1'b0;
    for (int e = 0; e < NUM_ENTRIES; e++) begin
      if (mdl_busy[e] && mdl_addr[e] == addrs[p]) begin
        seen = 1'b1;
      end
    end
    for (int q = 0; q < p; q++) begin
      if (valid[q] && addrs[q] == addrs[p]) begin
        seen = 1'b1;
      end
    end
    if (valid[p] && !seen && mdl_state != dmiss_pkg::RS_REPLAY) begin
      if (rank < free_entries()) begin
        acc[p] = 1'b1;
      end
      rank++;
    end
  end
  return acc;
endfunction

function automatic dmiss_pkg::line_addr_t expected_rd_addr(input logic [IDX_W-1:0] idx);
  return mdl_busy[idx] ? mdl_addr[idx] : '0;
endfunction

function automatic void advance_model(
  input logic [NUM_PORTS-1:0]                  valid,
  input dmiss_pkg::line_addr_t [NUM_PORTS-1:0] addrs,
  input logic [NUM_PORTS-1:0]                  acc,
  input logic                                  ren,
  input logic [IDX_W-1:0]                      idx,
  input logic                                  unl
);
  logic                   was_pending;
  logic [NUM_ENTRIES-1:0] taken;
  int                     slot;
  was_pending = |mdl_pending;
  taken       = mdl_busy;
  if (mdl_state == dmiss_pkg::RS_REPLAY && unl) begin
    mdl_busy    = '0;
    mdl_pending = '0;
    mdl_state   = dmiss_pkg::RS_IDLE;
  end else begin
    if (ren) begin
      mdl_pending[idx] = 1'b0;
    end
    // a new allocation overrides a read of the same slot.
    for (int p = 0; p < NUM_PORTS; p++) begin
      if (acc[p]) begin
        slot = -1;
        for (int e = 0; e < NUM_ENTRIES; e++) begin
          if (slot < 0 && !taken[e]) begin
            slot = e;
          end
        end
        if (slot >= 0) begin
          taken[slot]       = 1'b1;
          mdl_busy[slot]    = 1'b1;
          mdl_pending[slot] = 1'b1;
          mdl_addr[slot]    = addrs[p];
        end
      end
    end
    if (mdl_state == dmiss_pkg::RS_IDLE && (|acc)) begin
      mdl_state = dmiss_pkg::RS_COLLECT;
    end else if (mdl_state == dmiss_pkg::RS_COLLECT && !was_pending && !(|valid)
                 && !(|acc)) begin
      mdl_state = dmiss_pkg::RS_REPLAY;
    end
  end
endfunction

`endif

// File: dv/tb_dmiss_cam.sv
`timescale 1ns/1ps

module tb_dmiss_cam;

  localparam int NUM_PORTS      = 4;
  localparam int NUM_ENTRIES    = 8;
  localparam int IDX_W          = $clog2(NUM_ENTRIES);
  localparam int CLK_PERIOD     = 100;
  localparam int RESET_CYCLES   = 3;
  localparam int ROUNDS         = 28;
  localparam int TRAFFIC_CYCLES = 48;
  localparam int REPLAY_WAIT    = 4;
  localparam int LOCKED_CYCLES  = 6;
  localparam int ROUND_CYCLES   = TRAFFIC_CYCLES + NUM_ENTRIES + REPLAY_WAIT + LOCKED_CYCLES + 4;
  localparam int TEST_CYCLES    = RESET_CYCLES + ROUNDS * ROUND_CYCLES;
  localparam int WATCHDOG_CYCLES = TEST_CYCLES + 200;

  logic                                  clk;
  logic                                  rst;
  logic [NUM_PORTS-1:0]                  req_valid;
  dmiss_pkg::line_addr_t [NUM_PORTS-1:0] req_addr;
  logic [NUM_PORTS-1:0]                  accept_o;
  logic                                  has_free_o;
  logic                                  rd_en;
  logic [IDX_W-1:0]                      rd_idx;
  dmiss_pkg::line_addr_t                 rd_addr_o;
  logic                                  replay_o;
  logic                                  unlock;

  logic [31:0]          lfsr;
  logic [NUM_PORTS-1:0] exp_accept;
  int                   checks;
  int                   errors;

  `include "dmiss_model.svh"

  dmiss_cam #(
    .NUM_PORTS   (NUM_PORTS),
    .NUM_ENTRIES (NUM_ENTRIES)
  ) DUT (
    .clk         (clk),
    .rst         (rst),
    .req_valid_i (req_valid),
    .req_addr_i  (req_addr),
    .accept_o    (accept_o),
    .has_free_o  (has_free_o),
    .rd_en_i     (rd_en),
    .rd_idx_i    (rd_idx),
    .rd_addr_o   (rd_addr_o),
    .replay_o    (replay_o),
    .unlock_i    (unlock)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // galois form of x^32 + x^22 + x^2 + x + 1.
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  function automatic logic [31:0] draw_bits(input int n);
    logic [31:0] val;
    val = '0;
    for (int i = 0; i < n; i++) begin
      val  = {val[30:0], lfsr[0]};
      lfsr = lfsr_next(lfsr);
    end
    return val;
  endfunction

  // six lines per set, sets differ in bits 24 and 25.
  function automatic dmiss_pkg::line_addr_t pick_line(input int set_sel, input int slot);
    dmiss_pkg::line_addr_t line;
    case (slot)
      0: line = 36'h0_0000_0040;
      1: line = 36'h8_0000_0040;
      2: line = 36'h3_a5c1_0f12;
      3: line = 36'hf_ffff_fff0;
      4: line = 36'h0_0001_0040;
      default: line = 36'h7_1234_5678;
    endcase
    return line ^ (dmiss_pkg::line_addr_t'(set_sel) << 24);
  endfunction

  task automatic compare_value(input string name, input logic [63:0] exp_v,
                               input logic [63:0] act_v);
    checks++;
    assert (act_v === exp_v) else begin
      errors++;
      $display("FAIL t=%0t %s expected %h actual %h", $time, name, exp_v, act_v);
    end
  endtask

  task automatic drive_cycle(
    input logic [NUM_PORTS-1:0]                  valid,
    input dmiss_pkg::line_addr_t [NUM_PORTS-1:0] addrs,
    input logic                                  ren,
    input logic [IDX_W-1:0]                      idx,
    input logic                                  unl
  );
    @(posedge clk);
    req_valid <= valid;
    req_addr  <= addrs;
    rd_en     <= ren;
    rd_idx    <= idx;
    unlock    <= unl;
  endtask

  task automatic drive_idle();
    drive_cycle('0, '0, 1'b0, '0, 1'b0);
  endtask

  task automatic random_traffic(input int cycles, input int set_a, input int set_b,
                                input logic allow_unlock);
    logic [NUM_PORTS-1:0]                  valid;
    dmiss_pkg::line_addr_t [NUM_PORTS-1:0] addrs;
    logic                                  ren;
    logic [IDX_W-1:0]                      idx;
    logic                                  unl;
    int                                    set_sel;
    for (int c = 0; c < cycles; c++) begin
      set_sel = (c < cycles / 2) ? set_a : set_b;
      valid   = NUM_PORTS'(draw_bits(NUM_PORTS));
      for (int p = 0; p < NUM_PORTS; p++) begin
        addrs[p] = pick_line(set_sel, int'(draw_bits(3) % 32'd6));
      end
      ren = (draw_bits(2) == 32'd0);
      idx = IDX_W'(draw_bits(IDX_W));
      unl = allow_unlock && (draw_bits(4) == 32'd0) && (c != cycles - 1);
      drive_cycle(valid, addrs, ren, idx, unl);
    end
  endtask

  task automatic drain_reads();
    for (int e = 0; e < NUM_ENTRIES; e++) begin
      drive_cycle('0, '0, 1'b1, IDX_W'(e), 1'b0);
    end
  endtask

  task automatic wait_for_replay();
    int waited;
    waited = 0;
    drive_idle();
    // nothing was allocated since the last unlock.
    if (mdl_state != dmiss_pkg::RS_IDLE) begin
      @(negedge clk);
      while (!replay_o && waited < REPLAY_WAIT) begin
        drive_idle();
        @(negedge clk);
        waited++;
      end
      checks++;
      assert (replay_o) else begin
        errors++;
        $display("replay_o stayed low for %0d cycles after all entries were read", waited);
      end
    end
  endtask

  always @(negedge clk) begin
    if (rst) begin
      reset_model();
    end else begin
      exp_accept = predict_accept(req_valid, req_addr);
      compare_value("accept_o", 64'(exp_accept), 64'(accept_o));
      compare_value("has_free_o", 64'(free_entries() != 0), 64'(has_free_o));
      compare_value("rd_addr_o", 64'(expected_rd_addr(rd_idx)), 64'(rd_addr_o));
      compare_value("replay_o", 64'(mdl_state == dmiss_pkg::RS_REPLAY), 64'(replay_o));
      advance_model(req_valid, req_addr, exp_accept, rd_en, rd_idx, unlock);
    end
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("watchdog expired after %0d cycles, the test did not complete", WATCHDOG_CYCLES);
    $display("Simulation finished: FAIL");
    $finish;
  end

  initial begin
    clk       = 1'b0;
    rst       = 1'b1;
    req_valid = '0;
    req_addr  = '0;
    rd_en     = 1'b0;
    rd_idx    = '0;
    unlock    = 1'b0;
    checks    = 0;
    errors    = 0;
    lfsr      = 32'hf791_d5c0;
    repeat (RESET_CYCLES) @(posedge clk);
    rst <= 1'b0;
    for (int r = 0; r < ROUNDS; r++) begin
      // second half of a round reuses next round's first-half lines.
      random_traffic(TRAFFIC_CYCLES, r % 3, (r + 1) % 3, 1'b1);
      drain_reads();
      wait_for_replay();
      random_traffic(LOCKED_CYCLES, (r + 1) % 3, (r + 1) % 3, 1'b0);
      drive_cycle('0, '0, 1'b0, '0, 1'b1);
      // lands in RS_IDLE, so it must be ignored.
      drive_cycle('0, '0, 1'b0, '0, 1'b1);
    end
    drive_idle();
    @(posedge clk);
    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

// File: files.f
+incdir+dv
src/dmiss_pkg.sv
src/miss_entry.sv
src/miss_alloc.sv
src/miss_replay.sv
src/dmiss_cam.sv
dv/tb_dmiss_cam.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the miss buffer testbench with Verilator.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

if ! verilator --binary --timing --assert \
    -f files.f \
    --top-module tb_dmiss_cam \
    -Mdir "$OBJ" -o sim_dmiss; then
  echo "Verilator build failed"
  exit 1
fi

"./$OBJ/sim_dmiss" > "$LOG" 2>&1
status=$?
cat "$LOG"

if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "Simulation finished: PASS" "$LOG"; then
  exit 0
fi

echo "pass message not found in $LOG"
exit 1
